// File: hw/masked_alu_pkg.sv
/*
 * Masked ALU shared definitions
 * Share and request layouts, opcode, result source, shift mode and
 * controller state encodings, and the mask-refresh LFSR seed
 */
package masked_alu_pkg;

  localparam int XLEN    = 32;
  localparam int SHAMT_W = 5;

  typedef logic [XLEN-1:0] word_t;

  localparam word_t PRNG_SEED = 32'h6789ABCD;

  // Two-share value, Boolean (s0 ^ s1) or arithmetic (s0 - s1)
  typedef struct packed {
    word_t s1;
    word_t s0;
  } shares_t;

  typedef enum logic [4:0] {
    OP_B_NOT    = 5'd0,
    OP_B_AND    = 5'd1,
    OP_B_IOR    = 5'd2,
    OP_B_XOR    = 5'd3,
    OP_B_ADD    = 5'd4,
    OP_B_SUB    = 5'd5,
    OP_B_SRLI   = 5'd6,
    OP_B_SLLI   = 5'd7,
    OP_B_RORI   = 5'd8,
    OP_B2A      = 5'd9,
    OP_A2B      = 5'd10,
    OP_B_MASK   = 5'd11,
    OP_B_REMASK = 5'd12,
    OP_A_MASK   = 5'd13,
    OP_A_REMASK = 5'd14,
    OP_A_ADD    = 5'd15,
    OP_A_SUB    = 5'd16
  } alu_op_e;

  // Wishbone write data, 133 bits
  typedef struct packed {
    alu_op_e op;
    shares_t rs1;
    shares_t rs2;
  } alu_req_t;

  typedef enum logic [2:0] {
    SRC_LOGIC  = 3'd0,
    SRC_ADDSUB = 3'd1,
    SRC_B2A    = 3'd2,
    SRC_SHIFT  = 3'd3,
    SRC_ENCODE = 3'd4
  } res_src_e;

  typedef enum logic [1:0] {SH_SRL, SH_SLL, SH_ROR} shift_mode_e;

  typedef enum logic [1:0] {ST_IDLE, ST_LOGIC, ST_ARITH, ST_DONE} ctl_state_e;

endpackage

// File: hw/masked_logic.sv
/*
 * Masked logic stage
 * Prepares operand shares per opcode and registers the threshold
 * AND cross terms and the XOR shares
 */
`timescale 1ns/1ns

module masked_logic (
  input  logic                     g_clk,
  input  logic                     g_resetn,
  input  logic                     i_en,
  input  masked_alu_pkg::alu_req_t i_req,
  input  masked_alu_pkg::word_t    i_gs,
  output masked_alu_pkg::shares_t  o_xor,
  output masked_alu_pkg::shares_t  o_and,
  output masked_alu_pkg::word_t    o_gs,
  output logic                     o_rdy
);

  masked_alu_pkg::word_t a0, a1, b0, b1;
  masked_alu_pkg::word_t t0_q, t1_q, t2_q, t3_q;

  always_comb begin
    a0 = i_req.rs1.s0;
    a1 = i_req.rs1.s1;
    b0 = i_req.rs2.s0;
    b1 = i_req.rs2.s1;
    case (i_req.op)
      masked_alu_pkg::OP_B_IOR: begin
        a1 = ~i_req.rs1.s1;     // ~a & ~b, inverted again in the top
        b1 = ~i_req.rs2.s1;
      end
      masked_alu_pkg::OP_B_SUB: b1 = ~i_req.rs2.s1;
      masked_alu_pkg::OP_B2A: begin
        b0 = i_gs;              // x + r, r becomes the arithmetic mask
        b1 = '0;
      end
      masked_alu_pkg::OP_A2B: begin
        a1 = '0;
        b0 = i_gs;
        b1 = ~i_req.rs1.s1 ^ i_gs;  // Refreshed and inverted for s0 - s1
      end
      default: ;
    endcase
  end

  // Threshold cross terms, each share pair kept apart until after the flop
  always_ff @(posedge g_clk) begin
    if (i_en) begin
      o_xor.s0 <= a0 ^ b0;
      o_xor.s1 <= a1 ^ b1;
      t0_q     <= i_gs ^ (a0 & b0);
      t1_q     <= i_gs ^ (a0 & b1);
      t2_q     <= a1 & b0;
      t3_q     <= a1 & b1;
      o_gs     <= a1;
    end
  end

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      o_rdy <= 1'b0;
    end else begin
      o_rdy <= i_en;
    end
  end

  assign o_and.s0 = t0_q ^ t2_q;
  assign o_and.s1 = t1_q ^ t3_q;

endmodule

// File: hw/masked_addsub.sv
/*
 * Masked Boolean adder/subtractor
 * Kogge-Stone carry sequencer on two shares, one span per step,
 * followed by the sum post-processing with the subtract carry-in
 */
`timescale 1ns/1ns

module masked_addsub (
  input  logic                    g_clk,
  input  logic                    g_resetn,
  input  logic                    i_abort,
  input  logic                    i_en,
  input  logic                    i_sub,
  input  masked_alu_pkg::word_t   i_gs,
  input  masked_alu_pkg::shares_t i_xor,
  input  masked_alu_pkg::shares_t i_and,
  output masked_alu_pkg::shares_t o_sum,
  output logic                    o_rdy
);

  logic [2:0] step;
  logic       first;
  logic [4:0] span;
  logic       g_live, p_live;

  masked_alu_pkg::word_t gs_in, p0_in, p1_in, g0_in, g1_in;
  masked_alu_pkg::word_t gj0, gj1, pj0, pj1;
  masked_alu_pkg::word_t tg0_q, tg1_q, tg2_q, tg3_q;
  masked_alu_pkg::word_t tp0_q, tp1_q, tp2_q, tp3_q;
  masked_alu_pkg::word_t gs_q;
  masked_alu_pkg::word_t g0, g1, p0, p1;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      step <= 3'd1;
    end else if (i_abort || o_rdy) begin
      step <= 3'd1;
    end else if (i_en) begin
      step <= step + 3'd1;
    end
  end

  assign o_rdy = (step == 3'd6);
  assign first = (step == 3'd1);

  assign g0 = tg0_q ^ tg2_q;
  assign g1 = tg1_q ^ tg3_q;
  assign p0 = tp0_q ^ tp2_q;
  assign p1 = tp1_q ^ tp3_q;

  // First step starts from the logic stage; carry-in folded into bit 0
  assign gs_in = first ? i_gs : gs_q;
  assign p0_in = first ? i_xor.s0 : p0;
  assign p1_in = first ? i_xor.s1 : p1;
  assign g0_in = first ? {i_and.s0[masked_alu_pkg::XLEN-1:1],
                          i_and.s0[0] ^ (i_sub & i_xor.s0[0])} : g0;
  assign g1_in = first ? {i_and.s1[masked_alu_pkg::XLEN-1:1],
                          i_and.s1[0] ^ (i_sub & i_xor.s1[0])} : g1;

  always_comb begin
    span   = 5'd0;
    g_live = 1'b1;
    p_live = 1'b1;
    case (step)
      3'd1: span = 5'd1;
      3'd2: span = 5'd2;
      3'd3: span = 5'd4;
      3'd4: span = 5'd8;
      3'd5: begin
        span   = 5'd16;
        p_live = 1'b0;  // Last span needs no propagate
      end
      default: begin
        g_live = 1'b0;
        p_live = 1'b0;
      end
    endcase
  end

  assign gj0 = g_live ? (g0_in << span) : '0;
  assign gj1 = g_live ? (g1_in << span) : '0;
  assign pj0 = p_live ? (p0_in << span) : '0;
  assign pj1 = p_live ? (p1_in << span) : '0;

  // g ^= p & (g << span), p &= p << span, both as registered threshold terms
  always_ff @(posedge g_clk) begin
    if (i_en) begin
      tg0_q <= g0_in ^ (gj0 & p0_in);
      tg1_q <= g1_in ^ (gj1 & p0_in);
      tg2_q <= gj0 & p1_in;
      tg3_q <= gj1 & p1_in;
      tp0_q <= gs_in ^ (p0_in & pj0);
      tp1_q <= gs_in ^ (p0_in & pj1);
      tp2_q <= p1_in & pj0;
      tp3_q <= p1_in & pj1;
      gs_q  <= p0_in;                 // Guard for the next step
    end
  end

  assign o_sum.s0 = i_xor.s0 ^ {g0[masked_alu_pkg::XLEN-2:0], 1'b0};
  assign o_sum.s1 = i_xor.s1 ^ {g1[masked_alu_pkg::XLEN-2:0], i_sub};

  a_step_range: assert property (@(posedge g_clk) disable iff (!g_resetn)
    step inside {[3'd1:3'd6]});

endmodule

// File: hw/masked_shift.sv
/*
 * Masked shifter for one share
 * Five-level logical shift or rotate; vacated bits take padding from
 * the LFSR word so the padding cancels between the two shares
 */
`timescale 1ns/1ns

module masked_shift (
  input  masked_alu_pkg::word_t                i_share,
  input  logic [masked_alu_pkg::SHAMT_W-1:0]   i_shamt,
  input  masked_alu_pkg::word_t                i_pad,
  input  masked_alu_pkg::shift_mode_e          i_mode,
  output masked_alu_pkg::word_t                o_share
);

  masked_alu_pkg::word_t lvl [0:masked_alu_pkg::SHAMT_W];

  assign lvl[0] = i_share;

  for (genvar i = 0; i < masked_alu_pkg::SHAMT_W; i++) begin : g_stage
    logic [(1<<i)-1:0]     fill_r;  // Bits entering at the top on a right move
    logic [(1<<i)-1:0]     fill_l;
    masked_alu_pkg::word_t moved;

    // Each level takes its own slice of the padding word
    assign fill_l = i_pad[masked_alu_pkg::XLEN-(1<<i) -: (1<<i)];
    assign fill_r = (i_mode == masked_alu_pkg::SH_ROR) ? lvl[i][(1<<i)-1:0]
                                                       : i_pad[(1<<i)-1 +: (1<<i)];

    always_comb begin
      if (i_mode == masked_alu_pkg::SH_SLL) begin
        moved = {lvl[i][masked_alu_pkg::XLEN-(1<<i)-1:0], fill_l};
      end else begin
        moved = {fill_r, lvl[i][masked_alu_pkg::XLEN-1:(1<<i)]};
      end
    end

    assign lvl[i+1] = i_shamt[i] ? moved : lvl[i];
  end

  assign o_share = lvl[masked_alu_pkg::SHAMT_W];

endmodule

// File: hw/masked_encode.sv
/*
 * Mask encoding unit
 * Boolean and arithmetic mask and remask, and arithmetic add and
 * subtract done share by share
 */
`timescale 1ns/1ns

module masked_encode (
  input  masked_alu_pkg::alu_req_t i_req,
  input  masked_alu_pkg::word_t    i_prng,
  output masked_alu_pkg::shares_t  o_res
);

  masked_alu_pkg::word_t lhs0, rhs0, lhs1, rhs1;
  masked_alu_pkg::word_t asum0, asum1;
  logic                  cin;

  // Arithmetic operand selection, mask and remask add r to the shares
  always_comb begin
    lhs0 = i_req.rs1.s0;
    rhs0 = i_prng;
    lhs1 = i_req.rs1.s1;
    rhs1 = '0;
    cin  = 1'b0;
    case (i_req.op)
      masked_alu_pkg::OP_A_MASK:   lhs1 = i_prng;      // (x + r) - r
      masked_alu_pkg::OP_A_REMASK: rhs1 = i_prng;
      masked_alu_pkg::OP_A_ADD: begin
        rhs0 = i_req.rs2.s0;
        rhs1 = i_req.rs2.s1;
      end
      masked_alu_pkg::OP_A_SUB: begin
        rhs0 = ~i_req.rs2.s0;
        rhs1 = ~i_req.rs2.s1;
        cin  = 1'b1;
      end
      default: ;
    endcase
  end

  assign asum0 = lhs0 + rhs0 + cin;
  assign asum1 = lhs1 + rhs1 + cin;

  always_comb begin
    case (i_req.op)
      masked_alu_pkg::OP_B_MASK: begin
        o_res.s0 = i_req.rs1.s0 ^ i_prng;
        o_res.s1 = i_prng;
      end
      masked_alu_pkg::OP_B_REMASK: begin
        o_res.s0 = i_req.rs1.s0 ^ i_prng;
        o_res.s1 = i_req.rs1.s1 ^ i_prng;
      end
      default: begin
        o_res.s0 = asum0;
        o_res.s1 = asum1;
      end
    endcase
  end

endmodule

// File: hw/masked_alu_ctl.sv
/*
 * Masked ALU controller
 * Decodes the opcode, sequences the logic and adder units, raises the
 * Wishbone acknowledge and steps the mask-refresh LFSR on it
 */
`timescale 1ns/1ns

module masked_alu_ctl (
  input  logic                        g_clk,
  input  logic                        g_resetn,
  input  logic                        i_wb_cyc,
  input  logic                        i_wb_stb,
  input  masked_alu_pkg::alu_op_e     i_op,
  input  logic                        i_logic_rdy,
  input  logic                        i_addsub_rdy,
  output logic                        o_logic_en,
  output logic                        o_addsub_en,
  output logic                        o_sub,
  output masked_alu_pkg::res_src_e    o_src,
  output masked_alu_pkg::shift_mode_e o_shift_mode,
  output masked_alu_pkg::word_t       o_prng,
  output masked_alu_pkg::word_t       o_prng_next,
  output logic                        o_wb_ack
);

  masked_alu_pkg::ctl_state_e state, state_nxt;
  logic req;
  logic need_logic;   // Registered threshold AND/XOR stage
  logic need_adder;   // Iterative carry sequencer behind it
  logic fb;

  assign req = i_wb_cyc && i_wb_stb;

  always_comb begin
    need_logic   = 1'b0;
    need_adder   = 1'b0;
    o_sub        = 1'b0;
    o_src        = masked_alu_pkg::SRC_ENCODE;
    o_shift_mode = masked_alu_pkg::SH_SRL;
    case (i_op)
      masked_alu_pkg::OP_B_NOT: o_src = masked_alu_pkg::SRC_LOGIC;
      masked_alu_pkg::OP_B_AND, masked_alu_pkg::OP_B_IOR, masked_alu_pkg::OP_B_XOR: begin
        need_logic = 1'b1;
        o_src      = masked_alu_pkg::SRC_LOGIC;
      end
      masked_alu_pkg::OP_B_ADD, masked_alu_pkg::OP_B_SUB, masked_alu_pkg::OP_A2B: begin
        need_logic = 1'b1;
        need_adder = 1'b1;
        o_sub      = (i_op != masked_alu_pkg::OP_B_ADD); // Carry-in of one
        o_src      = masked_alu_pkg::SRC_ADDSUB;
      end
      masked_alu_pkg::OP_B2A: begin
        need_logic = 1'b1;
        need_adder = 1'b1;
        o_src      = masked_alu_pkg::SRC_B2A;
      end
      masked_alu_pkg::OP_B_SRLI: o_src = masked_alu_pkg::SRC_SHIFT;
      masked_alu_pkg::OP_B_SLLI: begin
        o_src        = masked_alu_pkg::SRC_SHIFT;
        o_shift_mode = masked_alu_pkg::SH_SLL;
      end
      masked_alu_pkg::OP_B_RORI: begin
        o_src        = masked_alu_pkg::SRC_SHIFT;
        o_shift_mode = masked_alu_pkg::SH_ROR;
      end
      default: ;
    endcase
  end

  always_comb begin
    state_nxt = state;
    case (state)
      masked_alu_pkg::ST_IDLE:
        if (req) state_nxt = need_logic ? masked_alu_pkg::ST_LOGIC : masked_alu_pkg::ST_DONE;
      masked_alu_pkg::ST_LOGIC:
        if (i_logic_rdy) begin
          state_nxt = need_adder ? masked_alu_pkg::ST_ARITH : masked_alu_pkg::ST_DONE;
        end
      masked_alu_pkg::ST_ARITH:
        if (i_addsub_rdy) state_nxt = masked_alu_pkg::ST_DONE;
      default: state_nxt = masked_alu_pkg::ST_IDLE;
    endcase
    if (!i_wb_cyc) state_nxt = masked_alu_pkg::ST_IDLE;  // Abort
  end

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      state <= masked_alu_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign o_logic_en  = req && need_logic && (state == masked_alu_pkg::ST_IDLE);
  assign o_addsub_en = i_wb_cyc && need_adder &&
                       ((state == masked_alu_pkg::ST_LOGIC && i_logic_rdy) ||
                        (state == masked_alu_pkg::ST_ARITH && !i_addsub_rdy));
  assign o_wb_ack    = (state == masked_alu_pkg::ST_DONE) && i_wb_cyc;

  // Fibonacci LFSR, taps 31 21 1 0 with XNOR feedback
  assign fb          = o_prng[31] ~^ o_prng[21] ~^ o_prng[1] ~^ o_prng[0];
  assign o_prng_next = {o_prng[30:0], fb};

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      o_prng <= masked_alu_pkg::PRNG_SEED;
    end else if (o_wb_ack) begin
      o_prng <= o_prng_next;              // One LFSR word per result
    end
  end

  a_ack_needs_stb: assert property (@(posedge g_clk) disable iff (!g_resetn)
    o_wb_ack |-> i_wb_stb);
  a_ack_single: assert property (@(posedge g_clk) disable iff (!g_resetn)
    o_wb_ack |=> !o_wb_ack);
  a_state_legal: assert property (@(posedge g_clk) disable iff (!g_resetn)
    !$isunknown(state) && state inside {masked_alu_pkg::ST_IDLE, masked_alu_pkg::ST_LOGIC,
                                        masked_alu_pkg::ST_ARITH, masked_alu_pkg::ST_DONE});

endmodule

// File: hw/masked_alu_top.sv
/*
 * Masked ALU top
 * Wishbone classic slave around the two-share ALU units; forms the
 * NOT, OR and B2A results and selects the returned result shares
 */
`timescale 1ns/1ns

module masked_alu_top (
  input  logic                     g_clk,
  input  logic                     g_resetn,
  input  logic                     i_wb_cyc,
  input  logic                     i_wb_stb,
  input  masked_alu_pkg::alu_req_t i_wb_dat,
  output logic                     o_wb_ack,
  output masked_alu_pkg::shares_t  o_wb_dat
);

  logic                        logic_en, logic_rdy;
  logic                        addsub_en, addsub_rdy;
  logic                        sub;
  masked_alu_pkg::res_src_e    src;
  masked_alu_pkg::shift_mode_e shift_mode;
  masked_alu_pkg::word_t       prng, prng_next, guard;
  masked_alu_pkg::shares_t     xor_sh, and_sh, sum_sh, enc_sh;
  masked_alu_pkg::shares_t     not_res, xor_res, ior_res, b2a_res, shift_res;

  masked_alu_ctl u_ctl (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .i_wb_cyc     (i_wb_cyc),
    .i_wb_stb     (i_wb_stb),
    .i_op         (i_wb_dat.op),
    .i_logic_rdy  (logic_rdy),
    .i_addsub_rdy (addsub_rdy),
    .o_logic_en   (logic_en),
    .o_addsub_en  (addsub_en),
    .o_sub        (sub),
    .o_src        (src),
    .o_shift_mode (shift_mode),
    .o_prng       (prng),
    .o_prng_next  (prng_next),
    .o_wb_ack     (o_wb_ack)
  );

  masked_logic u_logic (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_en     (logic_en),
    .i_req    (i_wb_dat),
    .i_gs     (prng_next),
    .o_xor    (xor_sh),
    .o_and    (and_sh),
    .o_gs     (guard),
    .o_rdy    (logic_rdy)
  );

  masked_addsub u_addsub (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_abort  (!i_wb_cyc),           // Dropped cycle kills the iteration
    .i_en     (addsub_en),
    .i_sub    (sub),
    .i_gs     (guard),
    .i_xor    (xor_sh),
    .i_and    (and_sh),
    .o_sum    (sum_sh),
    .o_rdy    (addsub_rdy)
  );

  // Same padding word on both shares so it cancels on unmasking
  masked_shift u_shift0 (
    .i_share (i_wb_dat.rs1.s0),
    .i_shamt (i_wb_dat.rs2.s0[masked_alu_pkg::SHAMT_W-1:0]),
    .i_pad   (prng),
    .i_mode  (shift_mode),
    .o_share (shift_res.s0)
  );

  masked_shift u_shift1 (
    .i_share (i_wb_dat.rs1.s1),
    .i_shamt (i_wb_dat.rs2.s0[masked_alu_pkg::SHAMT_W-1:0]),
    .i_pad   (prng),
    .i_mode  (shift_mode),
    .o_share (shift_res.s1)
  );

  masked_encode u_encode (
    .i_req  (i_wb_dat),
    .i_prng (prng),
    .o_res  (enc_sh)
  );

  assign not_res.s0 = i_wb_dat.rs1.s0 ^ prng_next;
  assign not_res.s1 = ~i_wb_dat.rs1.s1 ^ prng_next;
  assign xor_res.s0 = xor_sh.s0 ^ prng_next;  // Refresh before release
  assign xor_res.s1 = xor_sh.s1 ^ prng_next;
  assign ior_res.s0 = and_sh.s0;              // De Morgan on the inverted operands
  assign ior_res.s1 = ~and_sh.s1;

  // The adder saw prng_next as the arithmetic mask, so it becomes share 1
  assign b2a_res.s0 = sum_sh.s0 ^ sum_sh.s1;
  assign b2a_res.s1 = prng_next;

  always_comb begin
    case (src)
      masked_alu_pkg::SRC_LOGIC: begin
        case (i_wb_dat.op)
          masked_alu_pkg::OP_B_XOR: o_wb_dat = xor_res;
          masked_alu_pkg::OP_B_AND: o_wb_dat = and_sh;
          masked_alu_pkg::OP_B_IOR: o_wb_dat = ior_res;
          default:                  o_wb_dat = not_res;
        endcase
      end
      masked_alu_pkg::SRC_ADDSUB: o_wb_dat = sum_sh;
      masked_alu_pkg::SRC_B2A:    o_wb_dat = b2a_res;
      masked_alu_pkg::SRC_SHIFT:  o_wb_dat = shift_res;
      default:                    o_wb_dat = enc_sh;
    endcase
  end

endmodule

// File: sim/tb_clkgen.sv
/*
 * Testbench clock and reset generator
 * 100 ns clock, active-low reset held for the first 16 rising edges
 */
`timescale 1ns/1ns

module tb_clkgen (
  output logic o_clk,
  output logic o_resetn
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 16;
  localparam int RELEASE_DLY  = 5;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  initial begin
    o_resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #RELEASE_DLY o_resetn = 1'b1;  // Released off the edge like the other inputs
  end

endmodule

// File: sim/masked_alu_tb.sv
/*
 * Masked ALU testbench
 * Replays the request trace over Wishbone, unmasks each result share
 * pair and compares it with the expected value from the trace
 */
`timescale 1ns/1ns

module masked_alu_tb;

  localparam int    ACK_TIMEOUT   = 20;
  localparam int    RESET_TIMEOUT = 32;
  localparam int    IDLE_CHECKS   = 4;
  localparam int    ABORT_DELAY   = 3;   // Cycles into the add before the cycle is dropped
  localparam int    DRIVE_DLY     = 5;
  localparam string TRACE_FILE    = "sim/masked_alu_trace.txt";

  logic                     g_clk;
  logic                     g_resetn;
  logic                     wb_cyc;
  logic                     wb_stb;
  masked_alu_pkg::alu_req_t wb_dat;
  logic                     wb_ack;
  masked_alu_pkg::shares_t  wb_res;

  int n_checks;

  tb_clkgen u_clkgen (
    .o_clk    (g_clk),
    .o_resetn (g_resetn)
  );

  masked_alu_top dut (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_wb_cyc (wb_cyc),
    .i_wb_stb (wb_stb),
    .i_wb_dat (wb_dat),
    .o_wb_ack (wb_ack),
    .o_wb_dat (wb_res)
  );

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    n_checks++;
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("At %0t ns: %s", $time, why);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  // XOR for Boolean shares, subtraction for arithmetic shares
  function automatic logic [31:0] unmask(input masked_alu_pkg::shares_t sh, input byte dom);
    if (dom == "A") begin
      return sh.s0 - sh.s1;
    end else begin
      return sh.s0 ^ sh.s1;
    end
  endfunction

  task automatic start_request(input masked_alu_pkg::alu_req_t req);
    @(posedge g_clk);
    #DRIVE_DLY;
    wb_dat = req;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
  endtask

  // Result is taken at the falling edge, away from the flop updates
  task automatic wait_for_ack(output masked_alu_pkg::shares_t res);
    int cycles;
    cycles = 0;
    @(negedge g_clk);
    while (!wb_ack && cycles < ACK_TIMEOUT) begin
      @(negedge g_clk);
      cycles++;
    end
    if (!wb_ack) begin
      abort_run($sformatf("no acknowledge arrived within %0d cycles", ACK_TIMEOUT));
    end
    res = wb_res;
  endtask

  task automatic end_request();
    @(posedge g_clk);
    #DRIVE_DLY;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    @(negedge g_clk);
    check_equal({31'b0, wb_ack}, 32'd0, "acknowledge held for more than one cycle");
  endtask

  task automatic expect_no_ack(input int cycles, input string what);
    int n;
    for (n = 0; n < cycles; n++) begin
      @(negedge g_clk);
      check_equal({31'b0, wb_ack}, 32'd0, what);
    end
  endtask

  initial begin
    int                       fd;
    int                       n_fields;
    int                       line_no;
    int                       cycles;
    string                    line;
    int                       op_num;
    logic [31:0]              a0, a1, b0, b1, exp;
    byte                      dom;
    int                       abort;
    masked_alu_pkg::alu_req_t req;
    masked_alu_pkg::shares_t  res;

    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_dat   = '0;
    n_checks = 0;
    line_no  = 0;

    // No acknowledge during reset or while the bus is idle
    cycles = 0;
    @(negedge g_clk);
    while (!g_resetn && cycles < RESET_TIMEOUT) begin
      check_equal({31'b0, wb_ack}, 32'd0, "acknowledge during reset");
      @(negedge g_clk);
      cycles++;
    end
    if (g_resetn !== 1'b1) begin
      abort_run("reset was never released");
    end
    expect_no_ack(IDLE_CHECKS, "acknowledge without a strobe");
    n_checks = 0;   // Trace checks only from here on

    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      abort_run({"cannot open the trace file ", TRACE_FILE});
    end

    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) break;
      line_no++;
      if (line.len() < 2 || line[0] == "#") continue;   // Blank or comment line
      n_fields = $sscanf(line, "%d %h %h %h %h %h %c %d",
                         op_num, a0, a1, b0, b1, exp, dom, abort);
      if (n_fields != 8) begin
        abort_run($sformatf("trace line %0d could not be parsed", line_no));
      end

      req.op     = masked_alu_pkg::alu_op_e'(op_num[4:0]);
      req.rs1.s0 = a0;
      req.rs1.s1 = a1;
      req.rs2.s0 = b0;
      req.rs2.s1 = b1;
      start_request(req);

      if (abort != 0) begin
        repeat (ABORT_DELAY) @(posedge g_clk);
        #DRIVE_DLY;
        wb_cyc = 1'b0;                 // Drop the cycle mid-iteration
        wb_stb = 1'b0;
        expect_no_ack(ACK_TIMEOUT,
                      $sformatf("trace line %0d, acknowledge after abort", line_no));
      end else begin
        wait_for_ack(res);
        check_equal(unmask(res, dom), exp,
                    $sformatf("trace line %0d, op %0d, domain %c", line_no, op_num, dom));
        end_request();
      end
    end
    $fclose(fd);

    if (n_checks > 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("No trace line was checked");
      $display("Something failed");
      $fatal(1, "empty trace");
    end
  end

endmodule

// File: sim/masked_alu_trace.txt
# op rs1.s0 rs1.s1 rs2.s0 rs2.s1 expected domain abort
# op in decimal, shares and expected value in hex, domain B unmasks by XOR and A by subtraction
0  12345678 0f0f0f0f a5a5a5a5 3c3c3c3c e2c4a688 B 0
1  12345678 0f0f0f0f a5a5a5a5 3c3c3c3c 19191911 B 0
2  12345678 0f0f0f0f a5a5a5a5 3c3c3c3c 9dbbd9ff B 0
3  12345678 0f0f0f0f a5a5a5a5 3c3c3c3c 84a2c0ee B 0
4  12345678 0f0f0f0f a5a5a5a5 3c3c3c3c b6d4f310 B 0
5  12345678 0f0f0f0f a5a5a5a5 3c3c3c3c 83a1bfde B 0
4  ffff0000 0000ffff 5a5a5a5b 5a5a5a5a 00000000 B 0
5  c3c3c3c3 c3c3c3c3 00000001 00000000 ffffffff B 0
4  12345678 0f0f0f0f a5a5a5a5 3c3c3c3c 00000000 B 1
4  12345678 0f0f0f0f a5a5a5a5 3c3c3c3c b6d4f310 B 0
9  12345678 0f0f0f0f 00000000 00000000 1d3b5977 A 0
10 80000000 00000001 00000000 00000000 7fffffff B 0
10 12345678 9abcdef0 00000000 00000000 77777788 B 0
6  12345678 0f0f0f0f 00000024 00000000 01d3b597 B 0
7  12345678 0f0f0f0f 00000008 00000000 3b597700 B 0
8  12345678 0f0f0f0f 0000000c 00000000 9771d3b5 B 0
8  12345678 0f0f0f0f 00000001 00000000 8e9dacbb B 0
6  f0000000 00000000 0000001f 00000000 00000001 B 0
11 cafef00d 00000000 00000000 00000000 cafef00d B 0
12 12345678 0f0f0f0f 00000000 00000000 1d3b5977 B 0
13 13572468 00000000 00000000 00000000 13572468 A 0
14 12345678 9abcdef0 00000000 00000000 77777788 A 0
15 12345678 9abcdef0 00000010 00000001 77777797 A 0
16 12345678 9abcdef0 00000010 00000001 77777779 A 0

// File: filelist.f
hw/masked_alu_pkg.sv
hw/masked_logic.sv
hw/masked_addsub.sv
hw/masked_shift.sv
hw/masked_encode.sv
hw/masked_alu_ctl.sv
hw/masked_alu_top.sv
sim/tb_clkgen.sv
sim/masked_alu_tb.sv
